// ==== files.f ====
+incdir+.
illegal_pkg.sv
opcode_class_check.sv
field_check.sv
illegal_verdict.sv
illegal_detect_top.sv
illegal_properties.sv
illegal_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the illegal-instruction detector testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module illegal_tb \
   -Mdir obj_dir \
   -f files.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/Villegal_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
   echo "simulation failed with status $sim_status"
   exit 1
fi

exit 0

// ==== illegal_tb.sv ====
`include "illegal_defines.svh"

module illegal_tb
   import illegal_pkg::*;
();

   localparam int WAIT_LIMIT = 16;   // cycles to wait for result_valid
   localparam int BB_COUNT   = 20;   // back-to-back burst length

   logic                 clk;
   logic                 rst_n;
   logic                 instr_valid;
   logic [`ILL_XLEN-1:0] instr;
   logic                 core_running;
   logic                 result_valid;
   logic                 illegal;
   opcode_e              op_class;
   fault_e               fault;
   logic [`ILL_XLEN-1:0] trap_value;

   logic [`ILL_XLEN-1:0] exp_trap;   // model of the trap value register
   integer               seed;

   illegal_detect_top u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .core_running (core_running),
      .result_valid (result_valid),
      .illegal      (illegal),
      .op_class     (op_class),
      .fault        (fault),
      .trap_value   (trap_value)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // period 40
   end

   // ======================================
   // reference model
   // ======================================

   function automatic opcode_e expect_class(input logic [`ILL_XLEN-1:0] w);
      opcode_e c;
      case (w[6:0])               // full opcode, low bits included
         7'h03:   c = OP_LOAD;
         7'h0f:   c = OP_MISC_MEM;
         7'h13:   c = OP_IMM;
         7'h17:   c = OP_AUIPC;
         7'h23:   c = OP_STORE;
         7'h33:   c = OP_REG;
         7'h37:   c = OP_LUI;
         7'h63:   c = OP_BRANCH;
         7'h67:   c = OP_JALR;
         7'h6f:   c = OP_JAL;
         7'h73:   c = OP_SYSTEM;
         default: c = OP_INVALID;
      endcase
      return c;
   endfunction

   function automatic fault_e expect_fault(input logic [`ILL_XLEN-1:0] w);
      logic [6:0] f7;
      logic [2:0] f3;
      logic       reg_legal;
      fault_e     f;
      f7 = w[31:25];
      f3 = w[14:12];
      f  = FAULT_NONE;
      if (w[6:0] == 7'h13 && f3 == 3'b001 && f7 != 7'h00) f = FAULT_FUNCT7;   // slli
      if (w[6:0] == 7'h13 && f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20) begin
         f = FAULT_FUNCT7;   // srli/srai
      end
      if (w[6:0] == 7'h33) begin
         reg_legal = (f7 == 7'h00)
                  || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))
                  || (f7 == 7'h01 && `ILL_MULDIV);
         if (!reg_legal) f = FAULT_FUNCT7;
      end
      if (w[6:0] == 7'h73 && f3[1:0] == 2'b00 && (w[19:15] != 5'd0 || w[11:7] != 5'd0)) begin
         f = FAULT_SYS_REGS;   // env group with regs set
      end
      return f;
   endfunction

   // ======================================
   // encoders and random fields
   // ======================================

   function automatic logic [`ILL_XLEN-1:0] r_enc(input logic [6:0] f7, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
         input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [`ILL_XLEN-1:0] i_enc(input logic [11:0] imm, input logic [4:0] rs1,
         input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [4:0] rand_reg();
      logic [31:0] r;
      r = $random(seed);
      return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];   // never x0
   endfunction

   function automatic logic [6:0] bad_funct7();
      logic [31:0] r;
      logic [6:0]  f;
      r = $random(seed);
      f = r[31:25];
      if (f == 7'h00 || f == 7'h20 || f == 7'h01) f = 7'h7f;   // steer off legal set
      return f;
   endfunction

   function automatic logic [6:0] pick_opcode(input logic [3:0] sel, input logic [6:0] raw);
      case (sel)
         4'd0:    return 7'h03;
         4'd1:    return 7'h0f;
         4'd2:    return 7'h13;
         4'd3:    return 7'h17;
         4'd4:    return 7'h23;
         4'd5:    return 7'h33;
         4'd6:    return 7'h37;
         4'd7:    return 7'h63;
         4'd8:    return 7'h67;
         4'd9:    return 7'h6f;
         4'd10:   return 7'h73;
         default: return raw;   // random bits, mostly invalid
      endcase
   endfunction

   // ======================================
   // compare tasks
   // ======================================

   task automatic abort_with_fail();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_class(input opcode_e got, input opcode_e exp, input string tag);
      if (got !== exp) begin
         $display("FAILED at %0t: %s op_class %s, expected %s", $time, tag, got.name(),
                  exp.name());
         abort_with_fail();
      end
   endtask

   task automatic check_fault(input fault_e got, input fault_e exp, input string tag);
      if (got !== exp) begin
         $display("FAILED at %0t: %s fault %s, expected %s", $time, tag, got.name(),
                  exp.name());
         abort_with_fail();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string tag);
      if (got !== exp) begin
         $display("FAILED at %0t: %s got %b, expected %b", $time, tag, got, exp);
         abort_with_fail();
      end
   endtask

   task automatic check_word(input logic [`ILL_XLEN-1:0] got, input logic [`ILL_XLEN-1:0] exp,
         input string tag);
      if (got !== exp) begin
         $display("FAILED at %0t: %s trap_value %h, expected %h", $time, tag, got, exp);
         abort_with_fail();
      end
   endtask

   // ======================================
   // stimulus tasks
   // ======================================

   task automatic drive_word(input logic [`ILL_XLEN-1:0] w, input logic cr);
      @(negedge clk);
      instr_valid  = 1'b1;
      instr        = w;
      core_running = cr;
      @(negedge clk);
      instr_valid  = 1'b0;
      instr        = '0;   // word only meaningful with the strobe
   endtask

   task automatic wait_result(input string tag);
      int cycles;
      cycles = 0;
      while (result_valid !== 1'b1) begin
         if (cycles >= WAIT_LIMIT) begin
            $display("ERROR: no result_valid within %0d cycles for %s", WAIT_LIMIT, tag);
            abort_with_fail();
         end
         @(negedge clk);
         cycles = cycles + 1;
      end
   endtask

   task automatic check_result(input logic [`ILL_XLEN-1:0] w, input logic cr, input string tag);
      opcode_e c_exp;
      fault_e  f_exp;
      logic    ill_exp;
      c_exp   = expect_class(w);
      f_exp   = expect_fault(w);
      ill_exp = ((c_exp == OP_INVALID) || (f_exp != FAULT_NONE)) && cr;
      if (ill_exp) exp_trap = w;   // trap register loads the word
      check_bit(result_valid, 1'b1, {tag, " result_valid"});
      check_class(op_class, c_exp, tag);
      check_fault(fault, f_exp, tag);
      check_bit(illegal, ill_exp, {tag, " illegal"});
      check_word(trap_value, exp_trap, tag);
   endtask

   task automatic send_and_check(input logic [`ILL_XLEN-1:0] w, input logic cr, input string tag);
      drive_word(w, cr);
      wait_result(tag);
      check_result(w, cr, tag);
   endtask

   // ======================================
   // directed tests
   // ======================================

   task automatic test_reset_and_legal();
      check_bit(result_valid, 1'b0, "reset result_valid");
      check_bit(illegal, 1'b0, "reset illegal");
      check_class(op_class, OP_INVALID, "reset");
      check_fault(fault, FAULT_NONE, "reset");
      check_word(trap_value, '0, "reset");
      send_and_check(i_enc(12'h004, 5'd2, 3'b010, 5'd1, 7'h03), 1'b1, "lw");
      send_and_check(32'h0ff0000f, 1'b1, "fence");
      send_and_check(i_enc(12'h005, 5'd2, 3'b000, 5'd1, 7'h13), 1'b1, "addi");
      send_and_check({20'h00001, 5'd1, 7'h17}, 1'b1, "auipc");
      send_and_check(r_enc(7'h00, 5'd3, 5'd2, 3'b010, 5'd8, 7'h23), 1'b1, "sw");
      send_and_check(r_enc(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'h33), 1'b1, "add");
      send_and_check({20'h12345, 5'd5, 7'h37}, 1'b1, "lui");
      send_and_check(r_enc(7'h00, 5'd3, 5'd2, 3'b000, 5'd8, 7'h63), 1'b1, "beq");
      send_and_check(i_enc(12'h000, 5'd1, 3'b000, 5'd0, 7'h67), 1'b1, "jalr");
      send_and_check({20'h00100, 5'd1, 7'h6f}, 1'b1, "jal");
      send_and_check(32'h00000073, 1'b1, "ecall");
   endtask

   task automatic test_illegal_opcode();
      logic [31:0] r;
      send_and_check(32'h00000010, 1'b1, "low bits 00");
      send_and_check(32'h00004501, 1'b1, "low bits 01");
      send_and_check(32'h00000012, 1'b1, "low bits 10");
      for (int m = 0; m < 32; m++) begin   // sweep every major pattern
         r = $random(seed);
         send_and_check({r[31:7], m[4:0], 2'b11}, 1'b1, $sformatf("major %0d", m));
      end
   endtask

   task automatic test_funct7();
      logic [2:0] f3v;
      send_and_check(r_enc(7'h00, 5'd3, rand_reg(), 3'b001, rand_reg(), 7'h13), 1'b1, "slli");
      send_and_check(r_enc(7'h20, 5'd3, rand_reg(), 3'b001, rand_reg(), 7'h13), 1'b1,
                     "slli alt");
      send_and_check(r_enc(bad_funct7(), 5'd3, rand_reg(), 3'b001, rand_reg(), 7'h13), 1'b1,
                     "slli bad");
      send_and_check(r_enc(7'h00, 5'd7, rand_reg(), 3'b101, rand_reg(), 7'h13), 1'b1, "srli");
      send_and_check(r_enc(7'h20, 5'd7, rand_reg(), 3'b101, rand_reg(), 7'h13), 1'b1, "srai");
      send_and_check(r_enc(bad_funct7(), 5'd7, rand_reg(), 3'b101, rand_reg(), 7'h13), 1'b1,
                     "srli bad");
      for (int f3 = 0; f3 < 8; f3++) begin   // add..and, sub/sra, mul group
         f3v = f3[2:0];
         send_and_check(r_enc(7'h00, rand_reg(), rand_reg(), f3v, rand_reg(), 7'h33), 1'b1,
                        $sformatf("reg f3 %0d base", f3));
         send_and_check(r_enc(7'h20, rand_reg(), rand_reg(), f3v, rand_reg(), 7'h33), 1'b1,
                        $sformatf("reg f3 %0d alt", f3));
         send_and_check(r_enc(7'h01, rand_reg(), rand_reg(), f3v, rand_reg(), 7'h33), 1'b1,
                        $sformatf("reg f3 %0d muldiv", f3));
         send_and_check(r_enc(bad_funct7(), rand_reg(), rand_reg(), f3v, rand_reg(), 7'h33),
                        1'b1, $sformatf("reg f3 %0d bad", f3));
      end
   endtask

   task automatic test_system();
      send_and_check(32'h00000073, 1'b1, "ecall");
      send_and_check(32'h00100073, 1'b1, "ebreak");
      send_and_check(32'h30200073, 1'b1, "mret");
      send_and_check(32'h10500073, 1'b1, "wfi");
      send_and_check(i_enc(12'h000, 5'd0, 3'b000, rand_reg(), 7'h73), 1'b1, "ecall rd");
      send_and_check(i_enc(12'h302, rand_reg(), 3'b000, 5'd0, 7'h73), 1'b1, "mret rs1");
      send_and_check(i_enc(12'h302, rand_reg(), 3'b000, rand_reg(), 7'h73), 1'b1, "mret both");
      for (int f3 = 1; f3 < 8; f3++) begin   // csr forms and funct3 100
         send_and_check(i_enc(12'h300, rand_reg(), f3[2:0], rand_reg(), 7'h73), 1'b1,
                        $sformatf("system f3 %0d", f3));
      end
   endtask

   task automatic test_core_gate();
      send_and_check(32'h12345678, 1'b1, "gate seed trap");   // known trap value
      send_and_check(32'h0000002b, 1'b0, "gate custom-1");
      send_and_check(r_enc(7'h40, 5'd3, 5'd2, 3'b000, 5'd1, 7'h33), 1'b0, "gate funct7");
      send_and_check(i_enc(12'h000, 5'd0, 3'b000, 5'd4, 7'h73), 1'b0, "gate sys regs");
      send_and_check(i_enc(12'h001, 5'd2, 3'b000, 5'd1, 7'h13), 1'b0, "gate legal");
   endtask

   task automatic test_back_to_back();
      logic [`ILL_XLEN-1:0] words [BB_COUNT];
      logic                 runs  [BB_COUNT];
      logic [31:0]          r;
      for (int i = 0; i < BB_COUNT; i++) begin
         r = $random(seed);
         words[i] = {r[31:7], pick_opcode(r[3:0], r[6:0])};
         r = $random(seed);
         runs[i] = (r[2:0] != 3'b000);   // mostly running
      end
      for (int i = 0; i <= BB_COUNT; i++) begin
         @(negedge clk);
         if (i > 0) begin
            check_result(words[i-1], runs[i-1], $sformatf("b2b word %0d", i - 1));
         end
         if (i < BB_COUNT) begin
            instr_valid  = 1'b1;
            instr        = words[i];
            core_running = runs[i];
         end else begin
            instr_valid  = 1'b0;
            instr        = '0;
         end
      end
      @(negedge clk);
      check_bit(result_valid, 1'b0, "b2b tail result_valid");
   endtask

   // ======================================
   // main sequence
   // ======================================

   initial begin
      seed         = 32'hc5fbaf96;
      rst_n        = 1'b0;
      instr_valid  = 1'b0;
      instr        = '0;
      core_running = 1'b0;
      exp_trap     = '0;
      repeat (5) @(posedge clk);   // reset over 5 rising edges
      @(negedge clk);
      rst_n        = 1'b1;
      core_running = 1'b1;
      test_reset_and_legal();
      test_illegal_opcode();
      test_funct7();
      test_system();
      test_core_gate();
      test_back_to_back();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== illegal_properties.sv ====
`include "illegal_defines.svh"

module illegal_properties (
   input logic                 clk,
   input logic                 rst_n,
   input logic                 instr_valid,
   input logic                 core_running,
   input logic                 result_valid,
   input logic                 illegal,
   input logic [`ILL_XLEN-1:0] trap_value
);

   // ======================================
   // handshake timing
   // ======================================

   a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid |=> result_valid)
      else $error("result_valid missing one cycle after instr_valid");

   a_valid_drops: assert property (@(posedge clk) disable iff (!rst_n)
      !instr_valid |=> !result_valid)
      else $error("result_valid high without a strobe");

   // ======================================
   // verdict and trap value
   // ======================================

   // verdict taken at the strobe edge, one edge back
   a_illegal_gated: assert property (@(posedge clk) disable iff (!rst_n)
      (result_valid && illegal) |-> $past(core_running))
      else $error("illegal reported while core was not running");

   a_trap_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (trap_value != $past(trap_value)) |-> (result_valid && illegal))
      else $error("trap_value changed without an illegal result");

endmodule

bind illegal_detect_top illegal_properties u_props (
   .clk          (clk),
   .rst_n        (rst_n),
   .instr_valid  (instr_valid),
   .core_running (core_running),
   .result_valid (result_valid),
   .illegal      (illegal),
   .trap_value   (trap_value)
);

// ==== illegal_detect_top.sv ====
`include "illegal_defines.svh"

module illegal_detect_top
   import illegal_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 instr_valid,   // fetch strobe
   input  logic [`ILL_XLEN-1:0] instr,         // fetched word
   input  logic                 core_running,
   output logic                 result_valid,
   output logic                 illegal,
   output opcode_e              op_class,      // registered class
   output fault_e               fault,         // registered fault
   output logic [`ILL_XLEN-1:0] trap_value
);

   opcode_e op_class_c;   // combinational class
   fault_e  fault_c;      // combinational fault

   // ======================================
   // checkers, both see the raw word
   // ======================================

   opcode_class_check u_opcode_class (
      .instr    (instr),
      .op_class (op_class_c)
   );

   field_check u_field (
      .instr (instr),
      .fault (fault_c)
   );

   // ======================================
   // verdict register
   // ======================================

   illegal_verdict u_verdict (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .core_running (core_running),
      .op_class     (op_class_c),
      .fault        (fault_c),
      .result_valid (result_valid),
      .illegal      (illegal),
      .op_class_q   (op_class),
      .fault_q      (fault),
      .trap_value   (trap_value)
   );

endmodule

// ==== illegal_verdict.sv ====
`include "illegal_defines.svh"

module illegal_verdict
   import illegal_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 instr_valid,   // one-cycle strobe
   input  logic [`ILL_XLEN-1:0] instr,         // word under check
   input  logic                 core_running,  // level, gates the verdict
   input  opcode_e              op_class,      // from opcode_class_check
   input  fault_e               fault,         // from field_check
   output logic                 result_valid,  // one cycle per strobe
   output logic                 illegal,       // gated verdict
   output opcode_e              op_class_q,
   output fault_e               fault_q,
   output logic [`ILL_XLEN-1:0] trap_value     // last illegal word
);

   logic illegal_d;   // verdict before the register

   // class and fault are reported even while the core is halted
   assign illegal_d = ((op_class == OP_INVALID) || (fault != FAULT_NONE)) && core_running;

   // ======================================
   // strobe stage
   // ======================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result_valid <= 1'b0;
      end else begin
         result_valid <= instr_valid;   // fixed one-cycle latency
      end
   end

   // results only move on a strobe, hold in between
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         illegal    <= 1'b0;
         op_class_q <= OP_INVALID;
         fault_q    <= FAULT_NONE;
      end else if (instr_valid) begin
         illegal    <= illegal_d;
         op_class_q <= op_class;
         fault_q    <= fault;
      end
   end

   // ======================================
   // trap value capture
   // ======================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         trap_value <= '0;
      end else if (instr_valid && illegal_d) begin
         trap_value <= instr;   // like mtval on an illegal trap
      end
   end

endmodule

// ==== field_check.sv ====
`include "illegal_defines.svh"

module field_check
   import illegal_pkg::*;
(
   input  logic [`ILL_XLEN-1:0] instr,  // word from fetch
   output fault_e               fault   // fault kind, none if fine
);

   // ======================================
   // field slices
   // ======================================

   logic [6:0] opcode;   // full 7-bit opcode incl low bits
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic [4:0] rs1;
   logic [4:0] rd;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1    = instr[19:15];
   assign rd     = instr[11:7];

   // ======================================
   // form recognition
   // ======================================

   logic shift_imm;      // slli/srli/srai
   logic reg_reg;        // OP_REG, any funct3
   logic sys_env;        // ecall/ebreak/mret/wfi group

   // only full opcodes count, so unknown opcodes never fault here
   assign shift_imm = (opcode == 7'b0010011) && (funct3[1:0] == 2'b01);
   assign reg_reg   = (opcode == 7'b0110011);
   assign sys_env   = (opcode == 7'b1110011) && (funct3[1:0] == 2'b00);

   // ======================================
   // funct7 rule
   // ======================================

   logic funct7_zero;    // 0000000
   logic funct7_alt;     // 0100000, sub/sra/srai
   logic funct7_mul;     // 0000001, M extension
   logic alt_allowed;    // funct3 takes the alt encoding
   logic imm_ok;
   logic reg_ok;
   logic funct7_bad;

   assign funct7_zero = (funct7 == 7'b0000000);
   assign funct7_alt  = (funct7 == 7'b0100000);
   assign funct7_mul  = (funct7 == 7'b0000001);

   // same test for both forms, shift imm already has funct3[1:0] == 01
   assign alt_allowed = (funct3 == 3'b000) || (funct3 == 3'b101);

   // slli wants zero, srli/srai zero or alt
   assign imm_ok = funct7_zero || (funct7_alt && alt_allowed);

   // add/sub and srl/sra take alt, mul group any funct3
   assign reg_ok = funct7_zero
                || (funct7_alt && alt_allowed)
                || (funct7_mul && `ILL_MULDIV);

   assign funct7_bad = (shift_imm && !imm_ok) || (reg_reg && !reg_ok);

   // ======================================
   // SYSTEM register rule
   // ======================================

   logic rs1_set;        // rs1 nonzero
   logic rd_set;         // rd nonzero
   logic sys_regs_bad;

   // imm12 itself is not checked, only rs1 and rd
   assign rs1_set      = (rs1 != 5'd0);
   assign rd_set       = (rd != 5'd0);
   assign sys_regs_bad = sys_env && (rs1_set || rd_set);

   // ======================================
   // fault kind
   // ======================================

   // funct7 first, though no form can raise both
   always_comb begin
      if (funct7_bad) begin
         fault = FAULT_FUNCT7;
      end else if (sys_regs_bad) begin
         fault = FAULT_SYS_REGS;
      end else begin
         fault = FAULT_NONE;
      end
   end

endmodule

// ==== opcode_class_check.sv ====
`include "illegal_defines.svh"

module opcode_class_check
   import illegal_pkg::*;
(
   input  logic [`ILL_XLEN-1:0] instr,     // word from fetch
   output opcode_e              op_class   // decoded class
);

   // ======================================
   // opcode fields
   // ======================================

   logic [4:0] major;   // bits 6..2
   logic       is_32b;  // low bits 11 mark a 32-bit encoding

   assign major  = instr[6:2];              // major opcode
   assign is_32b = (instr[1:0] == 2'b11);   // compressed space is illegal here

   // ======================================
   // class table
   // ======================================

   // funct and register fields are left to field_check
   always_comb begin
      op_class = OP_INVALID;                // default for holes
      if (is_32b) begin
         case (major)
            5'b00000: op_class = OP_LOAD;     // loads
            5'b00011: op_class = OP_MISC_MEM; // fence family
            5'b00100: op_class = OP_IMM;      // alu immediate
            5'b00101: op_class = OP_AUIPC;    // auipc
            5'b01000: op_class = OP_STORE;    // stores
            5'b01100: op_class = OP_REG;      // alu reg-reg
            5'b01101: op_class = OP_LUI;      // lui
            5'b11000: op_class = OP_BRANCH;   // conditional branches
            5'b11001: op_class = OP_JALR;     // jalr
            5'b11011: op_class = OP_JAL;      // jal
            5'b11100: op_class = OP_SYSTEM;   // csr and env calls
            // 00001 float load, 00010 custom-0, 00110 op-imm-32
            // 00111 48-bit, 01001 float store, 01010 custom-1
            // 01011 amo, 01110 op-32, 01111 64-bit, 10xxx fp
            // 11010 reserved, 11101 reserved, 11110 custom-3
            // 11111 80-bit and longer
            default:  op_class = OP_INVALID;  // unlisted pattern
         endcase
      end
   end

endmodule

// ==== illegal_pkg.sv ====
package illegal_pkg;

   // ======================================
   // major opcode classes
   // ======================================

   // the bits 6..2 pattern is noted next to each class
   typedef enum logic [3:0] {
      OP_LOAD     = 4'd0,   // 00000 lb/lh/lw/lbu/lhu
      OP_MISC_MEM = 4'd1,   // 00011 fence/fence.i
      OP_IMM      = 4'd2,   // 00100 addi..srai
      OP_AUIPC    = 4'd3,   // 00101
      OP_STORE    = 4'd4,   // 01000 sb/sh/sw
      OP_REG      = 4'd5,   // 01100 add..and, mul..remu
      OP_LUI      = 4'd6,   // 01101
      OP_BRANCH   = 4'd7,   // 11000 beq..bgeu
      OP_JALR     = 4'd8,   // 11001
      OP_JAL      = 4'd9,   // 11011
      OP_SYSTEM   = 4'd10,  // 11100 csr*, ecall, ebreak, mret, wfi
      OP_INVALID  = 4'd15   // anything else, or low bits not 11
   } opcode_e;

   // ======================================
   // field fault kinds
   // ======================================

   typedef enum logic [1:0] {
      FAULT_NONE     = 2'd0,  // fields look fine
      FAULT_FUNCT7   = 2'd1,  // bad funct7 on shift or reg-reg
      FAULT_SYS_REGS = 2'd2   // rs1 or rd set on ecall-like form
   } fault_e;

endpackage

// ==== illegal_defines.svh ====
`ifndef ILLEGAL_DEFINES_SVH
`define ILLEGAL_DEFINES_SVH

// ======================================
// build-time options
// ======================================

// instruction word width in bits
`define ILL_XLEN 32

// M extension support
// 1'b1 lets funct7 0000001 through on OP_REG, 1'b0 gives plain RV32I
`define ILL_MULDIV 1'b1

`endif
